// File: project.f
source/cmdseq_pkg.sv
source/ahb_cmd_slave.sv
source/cmd_addr_decoder.sv
source/cmd_buffer.sv
source/seq_regs.sv
source/cmd_sequencer.sv
source/cmdseq_top.sv
test/cmdseq_props.sv
test/tb_cmdseq.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmdseq
SEED      ?= 10
FLIST     := project.f
SRCS      := $(shell grep -v '^+' $(FLIST))
SIM       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FLIST) \
		--top-module $(TOP) -GSEED=$(SEED)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Finished with errors" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_cmdseq.sv
`timescale 1ns/1ps

module tb_cmdseq #(
    parameter int SEED = 10
);
    import cmdseq_pkg::*;

    localparam int ADDR_W  = 8;
    localparam int DEPTH   = 1 << ADDR_W;
    localparam int TIMEOUT = 4000;  // Cycles allowed per wait

    logic        clk;
    logic        rst_n;
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    bus_word_t   hwdata;
    bus_word_t   hrdata;
    logic        hreadyout;
    logic        ev_valid;
    out_event_t  ev;
    logic        busy;
    logic        done;

    bus_word_t   model_mem [DEPTH];  // Reference copy of the command buffer
    out_event_t  exp_ev [$];
    int          exp_gap [$];        // Minimum cycles since the previous event
    out_event_t  got_ev [$];
    int          got_cyc [$];
    bus_word_t   rng;
    int          cycle;
    int          checks;
    int          errors;

    cmdseq_top #(.ADDR_W(ADDR_W)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Event monitor, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && ev_valid) begin
            got_ev.push_back(ev);
            got_cyc.push_back(cycle);
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic bus_word_t next_rand();
        rng = rng ^ (rng << 13);  // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [11:0] buf_off(input int idx);
        return 12'h800 | 12'((idx % DEPTH) << 2);  // Buffer window, word aligned
    endfunction

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_event(input string name, input out_event_t exp, input out_event_t act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic ahb_write(input logic [11:0] offset, input bus_word_t data);
        @(posedge clk);
        hsel   <= 1'b1;
        haddr  <= {20'h0, offset};
        htrans <= 2'b10;  // NONSEQ
        hwrite <= 1'b1;
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        hwdata <= data;   // Held through the data phase
    endtask

    task automatic ahb_read(input logic [11:0] offset, output bus_word_t data);
        @(posedge clk);
        hsel   <= 1'b1;
        haddr  <= {20'h0, offset};
        htrans <= 2'b10;
        hwrite <= 1'b0;
        @(posedge clk);
        hsel   <= 1'b0;   // Idle transfer follows the read
        htrans <= 2'b00;
        @(posedge clk);
        @(negedge clk);
        data = hrdata;    // Answer shows up one transfer later
        check_flag("hreadyout", 1'b1, hreadyout);  // No wait states on this slave
    endtask

    task automatic wait_status(input logic want_done, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((want_done ? done : busy) !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if ((want_done ? done : busy) !== 1'b1) begin
            $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
            errors++;
        end
    endtask

    // n random commands then END; the first is a long DELAY so a run outlasts a restart
    task automatic load_program(input int ptr, input int n);
        bus_word_t  lo;
        bus_word_t  hi;
        logic [1:0] op;
        for (int k = 0; k <= n; k++) begin
            op = (k == n) ? 2'd0 : (k == 0) ? 2'd2 : 2'(1 + next_rand() % 3);
            lo = next_rand();
            if (op == 2'd2) lo = (k == 0) ? 32'd8 + (lo & 32'h7) : lo & 32'hf;
            hi      = next_rand();
            hi[1:0] = op;                                // Rotated up into the opcode
            model_mem[(ptr + 2 * k) % DEPTH]     = lo;
            model_mem[(ptr + 2 * k + 1) % DEPTH] = hi;
            ahb_write(buf_off(ptr + 2 * k), lo);
            ahb_write(buf_off(ptr + 2 * k + 1), hi);
        end
    endtask

    task automatic store_word(input int idx, input bus_word_t w);
        model_mem[idx % DEPTH] = w;
        ahb_write(buf_off(idx), w);
    endtask

    // Reference decode of the model memory into expected events
    task automatic build_expected(input int ptr);
        logic [63:0] cmd;
        int          gap;
        int          p;
        exp_ev.delete();
        exp_gap.delete();
        p   = ptr % DEPTH;
        gap = 3;
        for (int k = 0; k < DEPTH / 2; k++) begin
            cmd = {model_mem[(p + 1) % DEPTH][1:0], model_mem[(p + 1) % DEPTH][31:2],
                   model_mem[p]};
            if (cmd[63:62] == 2'd0) break;               // END
            if (cmd[63:62] == 2'd1) begin                // WRITE
                exp_ev.push_back({cmd[61:48], cmd[31:0]});
                exp_gap.push_back(gap);
                gap = 3;
            end else if (cmd[63:62] == 2'd2) begin       // DELAY, count 0 acts as 1
                gap += (cmd[15:0] == 16'd0) ? 1 : int'(cmd[15:0]);
            end
            p = (p + 2) % DEPTH;
        end
    endtask

    task automatic run_program(input int ptr, input string name, input bit restart,
                               input bit collide);
        bus_word_t w;
        int        alt;
        got_ev.delete();
        got_cyc.delete();
        alt = (ptr + DEPTH / 2) % DEPTH;
        if (restart) begin                               // Decoy WRITE then END at alt
            store_word(alt, next_rand());
            w      = next_rand();
            w[1:0] = 2'd1;                               // WRITE
            store_word(alt + 1, w);
            store_word(alt + 2, '0);
            store_word(alt + 3, '0);                     // END
        end
        build_expected(ptr);
        ahb_write(REG_START_PTR, 32'(ptr));
        ahb_write(REG_CTRL, 32'h1);
        wait_status(1'b0, {name, " to go busy"});
        if (done !== 1'b0) begin
            $display("done is still set after %s started", name);
            errors++;
        end
        if (restart) begin
            ahb_write(REG_START_PTR, 32'(alt));          // Only a taken restart lands here
            ahb_write(REG_CTRL, 32'h1);                  // Must be ignored while busy
        end
        if (collide) begin
            for (int k = 0; k < 16; k++) begin           // Words well clear of the program
                w = next_rand();
                model_mem[(ptr + 128 + k) % DEPTH] = w;
                ahb_write(buf_off(ptr + 128 + k), w);
            end
        end
        wait_status(1'b1, {name, " to finish"});
        if (got_ev.size() != exp_ev.size()) begin
            $display("%s gave %0d events where %0d were expected",
                     name, got_ev.size(), exp_ev.size());
            errors++;
        end
        for (int i = 0; i < exp_ev.size() && i < got_ev.size(); i++) begin
            check_event(name, exp_ev[i], got_ev[i]);
            if (i > 0 && got_cyc[i] - got_cyc[i-1] < exp_gap[i]) begin
                $display("%s event %0d came %0d cycles after the one before, need %0d",
                         name, i, got_cyc[i] - got_cyc[i-1], exp_gap[i]);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        bus_word_t w;
        int        idx;
        int        wr_idx [$];
        rng    = SEED;
        cycle  = 0;
        checks = 0;
        errors = 0;
        rst_n  = 1'b0;
        hsel   = 1'b0;
        haddr  = '0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = '0;
        for (int i = 0; i < DEPTH; i++) model_mem[i] = '0;  // Buffer clears at reset
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        ahb_read(REG_STATUS, w);
        check_word("status after reset", 32'h0, w);
        idx = next_rand() % DEPTH;
        ahb_write(REG_START_PTR, 32'(idx));
        ahb_read(REG_START_PTR, w);
        check_word("start_ptr readback", 32'(idx), w);

        for (int k = 0; k < 40; k++) begin                  // Buffer fill and readback
            idx = next_rand() % DEPTH;
            w   = next_rand();
            model_mem[idx] = w;
            wr_idx.push_back(idx);
            ahb_write(buf_off(idx), w);
        end
        foreach (wr_idx[k]) begin
            ahb_read(buf_off(wr_idx[k]), w);
            check_word("buffer readback", model_mem[wr_idx[k]], w);
        end

        for (int k = 0; k < 6; k++) begin
            idx = next_rand() % DEPTH;
            load_program(idx, 3 + next_rand() % 6);
            run_program(idx, "random program", 1'b0, 1'b0);
        end
        ahb_read(REG_STATUS, w);
        check_word("status after end", 32'h2, w);           // done=1, busy=0

        load_program(DEPTH - 2, 5);                         // Runs over the top into index 0
        run_program(DEPTH - 2, "wrapped program", 1'b1, 1'b0);
        idx = next_rand() % DEPTH;
        load_program(idx, 6);
        run_program(idx, "program under bus writes", 1'b0, 1'b1);

        repeat (4) @(posedge clk);
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/cmdseq_props.sv
`timescale 1ns/1ps

module cmdseq_props (
    input logic clk,
    input logic rst_n,
    input logic ev_valid,
    input logic cmd_rd_en,
    input logic busy,
    input logic done
);

    // Events only come out of a running program
    ev_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) ev_valid |-> busy)
        else $error("ev_valid high while the sequencer is idle");

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high together");

    // No buffer fetch from an idle sequencer
    fetch_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) cmd_rd_en |-> busy)
        else $error("cmd_rd_en high while the sequencer is idle");

endmodule

bind cmd_sequencer cmdseq_props i_props (
    .clk, .rst_n, .ev_valid, .cmd_rd_en,
    .busy(status.busy),
    .done(status.done)
);

// File: source/cmdseq_top.sv
`timescale 1ns/1ps

module cmdseq_top #(
    parameter int ADDR_W = 8  // Buffer depth 2**ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hsel,
    input  logic [31:0]            haddr,
    input  logic [1:0]             htrans,
    input  logic                   hwrite,
    input  cmdseq_pkg::bus_word_t  hwdata,
    output cmdseq_pkg::bus_word_t  hrdata,
    output logic                   hreadyout,
    output logic                   ev_valid,
    output cmdseq_pkg::out_event_t ev,
    output logic                   busy,
    output logic                   done
);
    import cmdseq_pkg::*;

    // ------------------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------------------
    bus_req_t          req;
    logic              buf_en;
    logic              reg_en;
    logic [ADDR_W-1:0] trans_addr;
    bus_word_t         buf_rd_data;
    logic              buf_rd_valid;
    bus_word_t         reg_rd_data;
    logic              reg_rd_valid;
    logic              start;
    logic [ADDR_W-1:0] start_ptr;
    logic              cmd_rd_en;
    logic [ADDR_W-1:0] cmd_addr;
    logic              cmd_rd_valid;
    cmd_u              cmd;
    seq_status_t       status;

    assign busy = status.busy;
    assign done = status.done;

    ahb_cmd_slave i_slave (
        .clk, .rst_n, .hsel, .haddr, .htrans, .hwrite, .hwdata, .hrdata, .hreadyout,
        .req, .buf_rd_data, .buf_rd_valid, .reg_rd_data, .reg_rd_valid
    );

    cmd_addr_decoder #(.ADDR_W(ADDR_W)) i_decoder (
        .req, .buf_en, .reg_en, .trans_addr
    );

    cmd_buffer #(.ADDR_W(ADDR_W)) i_buffer (
        .clk, .rst_n, .buf_en, .trans_addr,
        .wr(req.write), .wdata(req.wdata),
        .rd_data(buf_rd_data), .rd_valid(buf_rd_valid),
        .cmd_rd_en, .cmd_addr, .cmd_rd_valid, .cmd
    );

    seq_regs #(.ADDR_W(ADDR_W)) i_regs (
        .clk, .rst_n, .reg_en, .offset(req.offset),
        .wr(req.write), .wdata(req.wdata),
        .rd_data(reg_rd_data), .rd_valid(reg_rd_valid),
        .status, .start, .start_ptr
    );

    cmd_sequencer #(.ADDR_W(ADDR_W)) i_seq (
        .clk, .rst_n, .start, .start_ptr,
        .cmd_rd_en, .cmd_addr, .cmd_rd_valid, .cmd,
        .ev_valid, .ev, .status
    );

endmodule

// File: source/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer #(
    parameter int ADDR_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Control from the register block
    input  logic                     start,
    input  logic [ADDR_W-1:0]        start_ptr,
    // Command fetch
    output logic                     cmd_rd_en,
    output logic [ADDR_W-1:0]        cmd_addr,
    input  logic                     cmd_rd_valid,
    input  cmdseq_pkg::cmd_u         cmd,
    // Output events and status
    output logic                     ev_valid,
    output cmdseq_pkg::out_event_t   ev,
    output cmdseq_pkg::seq_status_t  status
);
    import cmdseq_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,   // Read request to the buffer
        S_WAIT,    // Command arrives
        S_EXEC     // Act on it
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] ptr;       // Word index of the current command
    logic [ADDR_W-1:0] ptr_nxt;
    logic [15:0]       dly_cnt;
    opcode_e           op;

    assign ptr_nxt = ptr + ADDR_W'(2);  // Two words per command, wraps
    assign op      = cmd.wr.op;         // Same place in both views

    assign cmd_rd_en = (state == S_FETCH);
    assign cmd_addr  = ptr;

    // Write view carries the event
    assign ev_valid     = (state == S_EXEC) && (op == OP_WRITE);
    assign ev.port_addr = cmd.wr.port_addr;
    assign ev.data      = cmd.wr.data;

    // ------------------------------------------------------------------------
    // Fetch / execute FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            ptr     <= '0;
            dly_cnt <= '0;
            status  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin                // Start while busy never gets here
                        ptr         <= start_ptr;
                        status.busy <= 1'b1;
                        status.done <= 1'b0;
                        state       <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_WAIT;
                S_WAIT: begin
                    if (cmd_rd_valid) begin
                        dly_cnt <= cmd.dly.count;   // Delay view
                        state   <= S_EXEC;
                    end else begin
                        state <= S_FETCH;           // Blocked by a bus write, retry
                    end
                end
                S_EXEC: begin
                    case (op)
                        OP_END: begin
                            status.busy <= 1'b0;
                            status.done <= 1'b1;
                            state       <= S_IDLE;
                        end
                        OP_DELAY: begin
                            if (dly_cnt > 16'd1) begin
                                dly_cnt <= dly_cnt - 16'd1;
                            end else begin          // Count 0 ends after one cycle too
                                ptr   <= ptr_nxt;
                                state <= S_FETCH;
                            end
                        end
                        default: begin              // WRITE fires above, NOP does nothing
                            ptr   <= ptr_nxt;
                            state <= S_FETCH;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

// File: source/seq_regs.sv
`timescale 1ns/1ps

module seq_regs #(
    parameter int ADDR_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_en,
    input  logic [11:0]              offset,
    input  logic                     wr,
    input  cmdseq_pkg::bus_word_t    wdata,
    output cmdseq_pkg::bus_word_t    rd_data,
    output logic                     rd_valid,
    input  cmdseq_pkg::seq_status_t  status,
    output logic                     start,
    output logic [ADDR_W-1:0]        start_ptr
);
    import cmdseq_pkg::*;

    logic      reg_wr;
    logic      reg_rd;
    bus_word_t rd_mux;

    assign reg_wr = reg_en && wr;
    assign reg_rd = reg_en && !wr;

    // Read mux, unknown offsets read as zero
    always_comb begin
        rd_mux = '0;
        case (offset)
            REG_START_PTR: rd_mux = bus_word_t'(start_ptr);
            REG_STATUS:    rd_mux = bus_word_t'(status);   // {done, busy}
            default:       rd_mux = '0;                    // CTRL is write only
        endcase
    end

    // ------------------------------------------------------------------------
    // Register updates
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start     <= 1'b0;
            start_ptr <= '0;
            rd_data   <= '0;
            rd_valid  <= 1'b0;
        end else begin
            // One-cycle pulse, the cycle after the CTRL write
            start <= reg_wr && (offset == REG_CTRL) && wdata[0];
            if (reg_wr && (offset == REG_START_PTR)) start_ptr <= wdata[ADDR_W-1:0];
            rd_valid <= reg_rd;
            rd_data  <= reg_rd ? rd_mux : '0;
        end
    end

endmodule

// File: source/cmd_buffer.sv
`timescale 1ns/1ps

module cmd_buffer #(
    parameter int ADDR_W = 8  // Depth is 2**ADDR_W words
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Bus port
    input  logic                  buf_en,
    input  logic [ADDR_W-1:0]     trans_addr,
    input  logic                  wr,
    input  cmdseq_pkg::bus_word_t wdata,
    output cmdseq_pkg::bus_word_t rd_data,
    output logic                  rd_valid,
    // Sequencer port
    input  logic                  cmd_rd_en,
    input  logic [ADDR_W-1:0]     cmd_addr,
    output logic                  cmd_rd_valid,
    output cmdseq_pkg::cmd_u      cmd
);
    import cmdseq_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    bus_word_t         mem [DEPTH];
    logic              bus_wr;     // Bus write this cycle
    logic              bus_rd;     // Debug read this cycle
    logic [ADDR_W-1:0] cmd_addr_hi;
    bus_word_t         word_hi;

    assign bus_wr      = buf_en && wr;
    assign bus_rd      = buf_en && !wr;
    assign cmd_addr_hi = cmd_addr + 1'b1;   // Wraps at the top of the buffer
    assign word_hi     = mem[cmd_addr_hi];

    // ------------------------------------------------------------------------
    // Storage, bus write and debug read
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data      <= '0;
            rd_valid     <= 1'b0;
            cmd_rd_valid <= 1'b0;
        end else begin
            if (bus_wr) mem[trans_addr] <= wdata;
            rd_valid     <= bus_rd;
            rd_data      <= bus_rd ? mem[trans_addr] : '0;  // Zero when idle for OR merge
            cmd_rd_valid <= cmd_rd_en && !bus_wr;            // Bus write wins
        end
    end

    // Sequencer read, low two bits of the upper word rotate to the top
    always_ff @(posedge clk) begin
        if (cmd_rd_en && !bus_wr) begin
            cmd <= {word_hi[1:0], word_hi[31:2], mem[cmd_addr]};
        end
    end

endmodule

// File: source/cmd_addr_decoder.sv
`timescale 1ns/1ps

module cmd_addr_decoder #(
    parameter int ADDR_W = 8  // Buffer index width
) (
    input  cmdseq_pkg::bus_req_t req,
    output logic                 buf_en,
    output logic                 reg_en,
    output logic [ADDR_W-1:0]    trans_addr
);
    import cmdseq_pkg::*;

    logic in_buf;   // Offset lies in the buffer window
    logic in_regs;  // Offset lies in the register window

    // Buffer window is the upper half of the 4 KB slot
    assign in_buf  = req.offset[BUF_REGION];
    // Registers live in the first 16 bytes, the rest is a hole
    assign in_regs = (req.offset[11:4] == 8'h00);

    assign buf_en = req.valid && in_buf;
    assign reg_en = req.valid && in_regs;

    // Byte address to word index
    assign trans_addr = req.offset[ADDR_W+1:2];

endmodule

// File: source/ahb_cmd_slave.sv
`timescale 1ns/1ps

module ahb_cmd_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    // AHB-Lite side
    input  logic                  hsel,
    input  logic [31:0]           haddr,
    input  logic [1:0]            htrans,
    input  logic                  hwrite,
    input  cmdseq_pkg::bus_word_t hwdata,
    output cmdseq_pkg::bus_word_t hrdata,
    output logic                  hreadyout,
    // Internal request and readback
    output cmdseq_pkg::bus_req_t  req,
    input  cmdseq_pkg::bus_word_t buf_rd_data,
    input  logic                  buf_rd_valid,
    input  cmdseq_pkg::bus_word_t reg_rd_data,
    input  logic                  reg_rd_valid
);
    import cmdseq_pkg::*;

    logic        addr_ok;      // Address phase accepted this cycle
    logic        dp_valid;     // Data phase pending
    logic        dp_write;
    logic [11:0] dp_offset;
    logic        rd_pend;      // Read answer due this cycle
    bus_word_t   rd_merged;
    bus_word_t   rd_hold;      // Last read answer

    assign hreadyout = 1'b1;                  // No wait states
    assign addr_ok   = hsel && htrans[1];     // NONSEQ or SEQ

    // Address phase capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            dp_valid <= addr_ok;
            dp_write <= hwrite;
            rd_pend  <= dp_valid && !dp_write;  // Answer lands one cycle after req
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) dp_offset <= haddr[11:0];  // Only the window offset matters
    end

    // Data phase request, write data taken straight from the bus
    assign req.valid  = dp_valid;
    assign req.write  = dp_write;
    assign req.offset = dp_offset;
    assign req.wdata  = hwdata;

    // ------------------------------------------------------------------------
    // Readback merge; an unanswered read yields zero
    // ------------------------------------------------------------------------
    assign rd_merged = (buf_rd_valid ? buf_rd_data : '0)
                     | (reg_rd_valid ? reg_rd_data : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)       rd_hold <= '0;
        else if (rd_pend) rd_hold <= rd_merged;  // Held until the next read
    end

    assign hrdata = rd_pend ? rd_merged : rd_hold;

endmodule

// File: source/cmdseq_pkg.sv
package cmdseq_pkg;

    // ------------------------------------------------------------------------
    // Bus side types
    // ------------------------------------------------------------------------
    typedef logic [31:0] bus_word_t;  // One bus data word, also one buffer word

    // One accepted AHB transfer, valid for a single cycle
    typedef struct packed {
        logic        valid;
        logic        write;   // 1 = write, 0 = read
        logic [11:0] offset;  // Byte offset inside the slave window
        bus_word_t   wdata;
    } bus_req_t;

    // ------------------------------------------------------------------------
    // Command encoding
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_END   = 2'd0,
        OP_WRITE = 2'd1,
        OP_DELAY = 2'd2,
        OP_NOP   = 2'd3
    } opcode_e;

    // Write view, op sits in the rotated top bits
    typedef struct packed {
        opcode_e     op;
        logic [13:0] port_addr;
        logic [15:0] rsvd;
        bus_word_t   data;
    } cmd_wr_t;

    // Delay view
    typedef struct packed {
        opcode_e     op;
        logic [45:0] rsvd;
        logic [15:0] count;   // Cycles to wait, 0 behaves as 1
    } cmd_dly_t;

    typedef union packed {
        cmd_wr_t  wr;
        cmd_dly_t dly;
    } cmd_u;

    // Output port event
    typedef struct packed {
        logic [13:0] port_addr;
        bus_word_t   data;
    } out_event_t;

    typedef struct packed {
        logic done;  // Bit 1 of STATUS
        logic busy;  // Bit 0 of STATUS
    } seq_status_t;

    // Register map
    localparam logic [11:0] REG_CTRL      = 12'h000;  // Bit 0 write starts
    localparam logic [11:0] REG_START_PTR = 12'h004;
    localparam logic [11:0] REG_STATUS    = 12'h008;

    localparam int BUF_REGION = 11;  // Offset bit selecting the command buffer

endpackage
